// ==== design/cpuPkg.sv ====
package cpuPkg;

    ////////////////////////////////////////
    // Architectural constants
    ////////////////////////////////////////
    localparam logic [31:0] resetPc = 32'h0000_3000;

    // Data memory is 1K words
    localparam int memIndexW = 10;
    localparam int memWords  = 1 << memIndexW;

    // Opcodes
    localparam logic [5:0] opAdd0  = 6'h00;
    localparam logic [5:0] opOri   = 6'h0d;
    localparam logic [5:0] opLui   = 6'h0f;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] opSw    = 6'h2b;
    localparam logic [5:0] opJal   = 6'h03;
    localparam logic [5:0] opBeq   = 6'h04;
    localparam logic [5:0] opBsoal = 6'h3c;
    localparam logic [5:0] opLwrr  = 6'h3b;

    // Funct codes under opcode 0
    localparam logic [5:0] fnAdd = 6'h20;
    localparam logic [5:0] fnSub = 6'h22;
    localparam logic [5:0] fnJr  = 6'h08;

    ////////////////////////////////////////
    // Selector encodings
    ////////////////////////////////////////
    typedef enum logic [1:0] {aluAdd, aluSub, aluOr, aluLui} aluOpT;
    typedef enum logic [1:0] {npcPc4, npcBranch, npcJal, npcJr} npcSelT;
    typedef enum logic [1:0] {cmpNone, cmpEq, cmpSumOverflow} cmpOpT;
    typedef enum logic [1:0] {wrRt, wrRd, wr31} wrRegSelT;
    typedef enum logic [1:0] {wdAlu, wdMem, wdPc4} wrDataSelT;
    typedef enum logic {memWord, memReversed} memOpT;

    typedef struct packed {
        npcSelT    npcSel;
        cmpOpT     cmpOp;
        aluOpT     aluOp;
        logic      immSigned;
        logic      aluBImm;
        logic      regWrite;
        wrRegSelT  wrRegSel;
        wrDataSelT wrDataSel;
        logic      memWrite;
        memOpT     memOp;
    } controlT;

    ////////////////////////////////////////
    // Instruction word views
    ////////////////////////////////////////
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFormatT;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iFormatT;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] index;
    } jFormatT;

    typedef union packed {
        rFormatT r;
        iFormatT i;
        jFormatT j;
    } instrT;

    // One retired instruction
    typedef struct packed {
        logic [31:0] pc;
        instrT       instr;
        logic        regWrite;
        logic [4:0]  wrReg;
        logic [31:0] wrData;
        logic        memWrite;
        logic [31:0] memAddr;
        logic [31:0] memData;
    } commitT;

endpackage

// ==== design/controlUnit.sv ====
module controlUnit import cpuPkg::*; (
    input  instrT   instr,
    output controlT ctrl
);

    logic isAdd, isSub, isJr;
    logic isOri, isLui, isLw, isSw, isJal, isBeq, isBsoal, isLwrr;
    logic special;

    ////////////////////////////////////////
    // Instruction recognition
    ////////////////////////////////////////
    assign special = (instr.r.opcode == opAdd0);

    assign isAdd   = special && (instr.r.funct == fnAdd);
    assign isSub   = special && (instr.r.funct == fnSub);
    assign isJr    = special && (instr.r.funct == fnJr);
    assign isOri   = (instr.r.opcode == opOri);
    assign isLui   = (instr.r.opcode == opLui);
    assign isLw    = (instr.r.opcode == opLw);
    assign isSw    = (instr.r.opcode == opSw);
    assign isJal   = (instr.r.opcode == opJal);
    assign isBeq   = (instr.r.opcode == opBeq);
    assign isBsoal = (instr.r.opcode == opBsoal);
    assign isLwrr  = (instr.r.opcode == opLwrr);

    ////////////////////////////////////////
    // Control field generation
    ////////////////////////////////////////
    always_comb begin
        // Next PC source
        if (isBeq || isBsoal) begin
            ctrl.npcSel = npcBranch;
        end else if (isJal) begin
            ctrl.npcSel = npcJal;
        end else if (isJr) begin
            ctrl.npcSel = npcJr;
        end else begin
            ctrl.npcSel = npcPc4;
        end

        if (isBeq) begin
            ctrl.cmpOp = cmpEq;
        end else if (isBsoal) begin
            ctrl.cmpOp = cmpSumOverflow;
        end else begin
            ctrl.cmpOp = cmpNone;
        end

        // Loads and stores share the adder
        if (isSub) begin
            ctrl.aluOp = aluSub;
        end else if (isOri) begin
            ctrl.aluOp = aluOr;
        end else if (isLui) begin
            ctrl.aluOp = aluLui;
        end else begin
            ctrl.aluOp = aluAdd;
        end

        ctrl.immSigned = isLw || isSw || isLwrr;
        ctrl.aluBImm   = isOri || isLui || isLw || isSw || isLwrr;
        ctrl.regWrite  = isAdd || isSub || isOri || isLui || isLw || isLwrr
                         || isJal || isBsoal;

        if (isAdd || isSub) begin
            ctrl.wrRegSel = wrRd;
        end else if (isJal || isBsoal) begin
            ctrl.wrRegSel = wr31;
        end else begin
            ctrl.wrRegSel = wrRt;
        end

        if (isLw || isLwrr) begin
            ctrl.wrDataSel = wdMem;
        end else if (isJal || isBsoal) begin
            ctrl.wrDataSel = wdPc4;
        end else begin
            ctrl.wrDataSel = wdAlu;
        end

        ctrl.memWrite = isSw;
        ctrl.memOp    = isLwrr ? memReversed : memWord;
    end

endmodule

// ==== design/fetchUnit.sv ====
module fetchUnit import cpuPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  instrT       instr,
    input  npcSelT      npcSel,
    input  cmpOpT       cmpOp,
    input  logic [31:0] rsData,
    input  logic [31:0] rtData,
    input  logic        sumOverflow,
    output logic [31:0] pc,
    output logic [31:0] pcPlus4
);

    logic        condMet;
    logic [31:0] branchTarget;
    logic [31:0] jalTarget;
    logic [31:0] nextPc;

    assign pcPlus4 = pc + 32'd4;

    // Word offset relative to the following instruction
    assign branchTarget = pcPlus4 + {{14{instr.i.imm[15]}}, instr.i.imm, 2'b00};
    assign jalTarget    = {pcPlus4[31:28], instr.j.index, 2'b00};

    always_comb begin
        case (cmpOp)
            cmpEq:          condMet = (rsData == rtData);
            cmpSumOverflow: condMet = sumOverflow;
            default:        condMet = 1'b0;
        endcase
    end

    always_comb begin
        case (npcSel)
            npcBranch: nextPc = condMet ? branchTarget : pcPlus4;
            npcJal:    nextPc = jalTarget;
            npcJr:     nextPc = rsData;
            default:   nextPc = pcPlus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= resetPc;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

// ==== design/registerFile.sv ====
module registerFile (
    input  logic        clk,
    input  logic        rst,
    input  logic        we,
    input  logic [4:0]  rsAddr,
    input  logic [4:0]  rtAddr,
    input  logic [4:0]  wrAddr,
    input  logic [31:0] wrData,
    output logic [31:0] rsData,
    output logic [31:0] rtData
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wrAddr != 5'd0)) begin
            regs[wrAddr] <= wrData;
        end
    end

    // $zero is hardwired
    assign rsData = (rsAddr == 5'd0) ? 32'd0 : regs[rsAddr];
    assign rtData = (rtAddr == 5'd0) ? 32'd0 : regs[rtAddr];

endmodule

// ==== design/executeUnit.sv ====
module executeUnit import cpuPkg::*; (
    input  instrT       instr,
    input  controlT     ctrl,
    input  logic [31:0] rsData,
    input  logic [31:0] rtData,
    output logic [31:0] aluResult,
    output logic        sumOverflow
);

    logic [31:0] immExt;
    logic [31:0] opB;
    logic [31:0] rsRtSum;

    assign immExt = ctrl.immSigned ? {{16{instr.i.imm[15]}}, instr.i.imm}
                                   : {16'h0000, instr.i.imm};

    assign opB = ctrl.aluBImm ? immExt : rtData;

    always_comb begin
        case (ctrl.aluOp)
            aluSub:  aluResult = rsData - opB;
            aluOr:   aluResult = rsData | opB;
            aluLui:  aluResult = {instr.i.imm, 16'h0000};
            default: aluResult = rsData + opB;
        endcase
    end

    ////////////////////////////////////////
    // Signed overflow of rs+rt for bsoal
    ////////////////////////////////////////
    assign rsRtSum = rsData + rtData;

    // Same operand signs but result sign differs
    assign sumOverflow = (rsData[31] == rtData[31]) && (rsRtSum[31] != rsData[31]);

endmodule

// ==== design/dataMemory.sv ====
module dataMemory import cpuPkg::*; (
    input  logic        clk,
    input  logic        we,
    input  memOpT       memOp,
    input  logic [31:0] addr,
    input  logic [31:0] wrData,
    output logic [31:0] readData
);

    logic [31:0]          mem [memWords];
    logic [memIndexW-1:0] wordIdx;
    logic [31:0]          word;

    initial begin
        for (int i = 0; i < memWords; i++) begin
            mem[i] = '0;
        end
    end

    // Byte offset bits are ignored
    assign wordIdx = addr[memIndexW+1:2];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wordIdx] <= wrData;
        end
    end

    assign word = mem[wordIdx];

    always_comb begin
        if (memOp == memReversed) begin
            // lwrr swaps byte order end to end
            readData = {word[7:0], word[15:8], word[23:16], word[31:24]};
        end else begin
            readData = word;
        end
    end

endmodule

// ==== design/singleCycleCpu.sv ====
module singleCycleCpu import cpuPkg::*; (
    input  logic        clk,
    input  logic        rst,
    output logic [31:0] instrAddr,
    input  instrT       instr,
    output commitT      commit
);

    controlT     ctrl;
    logic [31:0] pc, pcPlus4;
    logic [31:0] rsData, rtData;
    logic [31:0] aluResult, readData;
    logic        sumOverflow;
    logic        regWe, memWe;
    logic [4:0]  wrReg;
    logic [31:0] wrData;

    assign instrAddr = pc;

    // No state changes while reset is held
    assign regWe = ctrl.regWrite && !rst;
    assign memWe = ctrl.memWrite && !rst;

    fetchUnit fetch (
        .clk, .rst, .instr, .npcSel(ctrl.npcSel), .cmpOp(ctrl.cmpOp),
        .rsData, .rtData, .sumOverflow, .pc, .pcPlus4
    );

    controlUnit control (.instr, .ctrl);

    registerFile regFile (
        .clk, .rst, .we(regWe), .rsAddr(instr.r.rs), .rtAddr(instr.r.rt),
        .wrAddr(wrReg), .wrData, .rsData, .rtData
    );

    executeUnit execute (.instr, .ctrl, .rsData, .rtData, .aluResult, .sumOverflow);

    dataMemory dataMem (
        .clk, .we(memWe), .memOp(ctrl.memOp), .addr(aluResult),
        .wrData(rtData), .readData
    );

    ////////////////////////////////////////
    // Writeback selection
    ////////////////////////////////////////
    always_comb begin
        case (ctrl.wrRegSel)
            wrRd:    wrReg = instr.r.rd;
            wr31:    wrReg = 5'd31;
            default: wrReg = instr.r.rt;
        endcase
        case (ctrl.wrDataSel)
            wdMem:   wrData = readData;
            wdPc4:   wrData = pcPlus4;
            default: wrData = aluResult;
        endcase
    end

    always_comb begin
        commit.pc       = pc;
        commit.instr    = instr;
        commit.regWrite = regWe;
        commit.wrReg    = wrReg;
        commit.wrData   = wrData;
        commit.memWrite = memWe;
        commit.memAddr  = aluResult;
        commit.memData  = rtData;
    end

endmodule

// ==== verification/singleCycleCpu_assertions.sv ====
module cpuAssertions import cpuPkg::*; (
    input logic        clk,
    input logic        rst,
    input commitT      commit,
    input instrT       instr,
    input logic [31:0] rsData
);

    timeunit 1ns;
    timeprecision 1ps;

    logic changesFlow;
    int   failures = 0;

    // Instructions that may leave the sequential path
    assign changesFlow = (commit.instr.r.opcode == opBeq)
                      || (commit.instr.r.opcode == opBsoal)
                      || (commit.instr.r.opcode == opJal)
                      || (commit.instr.r.opcode == opAdd0 && commit.instr.r.funct == fnJr);

    noWriteInReset: assert property (@(posedge clk)
        rst |-> !commit.regWrite && !commit.memWrite)
        else begin
            failures++;
            $error("state write committed during reset");
        end

    // A write lands in its register, except that register 0 keeps reading zero
    regWriteLands: assert property (@(posedge clk)
        !rst && $past(!rst) && $past(commit.regWrite) && instr.r.rs == $past(commit.wrReg)
        |-> rsData == ((instr.r.rs == 5'd0) ? 32'd0 : $past(commit.wrData)))
        else begin
            failures++;
            $error("register write not seen on the next read");
        end

    sequentialPc: assert property (@(posedge clk)
        !rst && $past(!rst) && !$past(changesFlow) |-> commit.pc == $past(commit.pc) + 32'd4)
        else begin
            failures++;
            $error("pc did not advance by 4");
        end

endmodule

bind singleCycleCpu cpuAssertions checks (.clk, .rst, .commit, .instr, .rsData);

// ==== verification/singleCycleCpuTb.sv ====
module singleCycleCpuTb import cpuPkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int progWords = 256;

    logic        clk;
    logic        rst;
    logic [31:0] instrAddr;
    instrT       instr;
    commitT      commit;

    logic [31:0] imem [progWords];

    // Reference machine state
    logic [31:0] mRegs [32];
    logic [31:0] mMem [1024];
    logic [31:0] mPc;

    logic [31:0] lcgState;
    logic        checking;
    int          checked;
    int          errors;
    int          testsPassed;
    int          testsFailed;

    singleCycleCpu UUT (.clk, .rst, .instrAddr, .instr, .commit);

    always #10 clk = ~clk;

    function automatic logic [31:0] fetchWord(logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - resetPc) >> 2;
        if (addr >= resetPc && idx < progWords && addr[1:0] == 2'b00) begin
            return imem[idx];
        end
        return 32'h0000_0000;
    endfunction

    // Instruction memory answers in the same cycle
    always_comb instr = fetchWord(instrAddr);

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic [31:0] encodeR(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                            logic [5:0] funct);
        return {opAdd0, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] encodeI(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                            logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] encodeJal(int target);
        logic [25:0] index;
        index = 26'((resetPc >> 2) + target);
        return {opJal, index};
    endfunction

    ////////////////////////////////////////
    // Reference ISA model
    ////////////////////////////////////////
    function automatic commitT stepModel();
        instrT       in;
        commitT      c;
        logic [31:0] rs, rt, pc4, sImm, zImm, nextPc, w, addr;
        longint      sum;
        in = fetchWord(mPc);
        rs = mRegs[in.r.rs];
        rt = mRegs[in.r.rt];
        pc4 = mPc + 32'd4;
        sImm = {{16{in.i.imm[15]}}, in.i.imm};
        zImm = {16'h0000, in.i.imm};
        addr = rs + sImm;
        c = '0;
        c.pc = mPc;
        c.instr = in;
        nextPc = pc4;
        case (in.r.opcode)
            opAdd0: begin
                if (in.r.funct == fnAdd || in.r.funct == fnSub) begin
                    c.regWrite = 1'b1;
                    c.wrReg = in.r.rd;
                    c.wrData = (in.r.funct == fnAdd) ? rs + rt : rs - rt;
                end else if (in.r.funct == fnJr) begin
                    nextPc = rs;
                end
            end
            opOri, opLui, opLw, opLwrr: begin
                w = mMem[addr[11:2]];
                c.regWrite = 1'b1;
                c.wrReg = in.i.rt;
                if (in.r.opcode == opOri) c.wrData = rs | zImm;
                else if (in.r.opcode == opLui) c.wrData = {in.i.imm, 16'h0000};
                else if (in.r.opcode == opLw) c.wrData = w;
                else c.wrData = {w[7:0], w[15:8], w[23:16], w[31:24]};
            end
            opSw: begin
                c.memWrite = 1'b1;
                c.memAddr = addr;
                c.memData = rt;
                mMem[addr[11:2]] = rt;
            end
            opJal, opBsoal: begin
                c.regWrite = 1'b1;
                c.wrReg = 5'd31;
                c.wrData = pc4;
                sum = longint'($signed(rs)) + longint'($signed(rt));
                if (in.r.opcode == opJal) begin
                    nextPc = {pc4[31:28], in.j.index, 2'b00};
                end else if (sum > 64'sd2147483647 || sum < -64'sd2147483648) begin
                    nextPc = pc4 + (sImm << 2);
                end
            end
            opBeq: begin
                if (rs == rt) nextPc = pc4 + (sImm << 2);
            end
            default: ;
        endcase
        if (c.regWrite && c.wrReg != 5'd0) mRegs[c.wrReg] = c.wrData;
        mPc = nextPc;
        return c;
    endfunction

    task automatic reportMismatch(string name, logic [31:0] expVal, logic [31:0] actVal);
        $display("Mismatch at %0t: %s expected %h actual %h", $time, name, expVal, actVal);
        errors++;
    endtask

    // Compare each committed instruction with the model
    always @(posedge clk) begin
        commitT e;
        if (checking) begin
            e = stepModel();
            if (commit.pc !== e.pc) reportMismatch("commit.pc", e.pc, commit.pc);
            if (commit.instr !== e.instr) reportMismatch("commit.instr", e.instr, commit.instr);
            if (commit.regWrite !== e.regWrite)
                reportMismatch("commit.regWrite", e.regWrite, commit.regWrite);
            if (e.regWrite && commit.wrReg !== e.wrReg)
                reportMismatch("commit.wrReg", e.wrReg, commit.wrReg);
            if (e.regWrite && commit.wrData !== e.wrData)
                reportMismatch("commit.wrData", e.wrData, commit.wrData);
            if (commit.memWrite !== e.memWrite)
                reportMismatch("commit.memWrite", e.memWrite, commit.memWrite);
            if (e.memWrite && commit.memAddr !== e.memAddr)
                reportMismatch("commit.memAddr", e.memAddr, commit.memAddr);
            if (e.memWrite && commit.memData !== e.memData)
                reportMismatch("commit.memData", e.memData, commit.memData);
            checked++;
        end
    end

    task automatic runProgram(string name, int count);
        int errBefore;
        int cycles;
        @(posedge clk);
        #2 rst = 1'b1;
        repeat (10) @(posedge clk);
        for (int i = 0; i < 32; i++) mRegs[i] = '0;
        mPc = resetPc;
        errBefore = errors;
        checked = 0;
        cycles = 0;
        #2 rst = 1'b0;
        checking = 1'b1;
        while (checked < count && cycles <= count + 20) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        // Core sits in reset while the next program loads
        rst = 1'b1;
        checking = 1'b0;
        if (checked < count) begin
            $display("Timeout: test %s committed only %0d instructions", name, checked);
            $display("Result: FAILED");
            $finish;
        end else if (errors == errBefore) begin
            testsPassed++;
            $display("Test %s: %0d instructions, ok", name, count);
        end else begin
            testsFailed++;
            $display("Test %s: %0d instructions, %0d errors", name, count, errors - errBefore);
        end
    endtask

    task automatic clearProgram();
        for (int i = 0; i < progWords; i++) imem[i] = 32'h0000_0000;
    endtask

    // Targets always stay inside the program array
    task automatic buildRandomProgram();
        logic [31:0] r;
        logic [4:0]  d;
        logic [15:0] off;
        imem[0] = encodeJal(1);
        for (int i = 1; i < progWords - 1; i++) begin
            r = nextRand();
            d = 5'(nextRand() % 31);
            off = 16'(int'(nextRand() % progWords) - (i + 1));
            case (r % 12)
                0: imem[i] = encodeR(r[9:5], r[14:10], d, fnAdd);
                1: imem[i] = encodeR(r[9:5], r[14:10], d, fnSub);
                2: imem[i] = encodeR(5'd31, 5'd0, 5'd0, fnJr);
                3: imem[i] = encodeI(opOri, r[9:5], d, r[31:16]);
                4: imem[i] = encodeI(opLui, 5'd0, d, r[31:16]);
                5: imem[i] = encodeI(opLw, r[9:5], d, r[31:16]);
                6: imem[i] = encodeI(opSw, r[9:5], r[14:10], r[31:16]);
                7: imem[i] = encodeJal(int'(nextRand() % progWords));
                8: imem[i] = encodeI(opBeq, r[9:5], r[14:10], off);
                9: imem[i] = encodeI(opBsoal, r[9:5], r[14:10], off);
                10: imem[i] = encodeI(opLwrr, r[9:5], d, r[31:16]);
                default: imem[i] = {6'h3e, r[25:0]};
            endcase
        end
        imem[progWords-1] = encodeI(opBeq, 5'd0, 5'd0, 16'(-progWords));
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        checking = 1'b0;
        errors = 0;
        testsPassed = 0;
        testsFailed = 0;
        lcgState = 32'h04d83c03;
        for (int i = 0; i < 1024; i++) mMem[i] = '0;

        ////////////////////////////////////////
        // Directed programs
        ////////////////////////////////////////
        clearProgram();
        imem[0] = encodeI(opOri, 5'd0, 5'd1, 16'h7fff);
        imem[1] = encodeI(opLui, 5'd0, 5'd2, 16'h7fff);
        imem[2] = encodeI(opOri, 5'd2, 5'd2, 16'hffff);
        imem[3] = encodeR(5'd2, 5'd1, 5'd3, fnAdd);
        imem[4] = encodeR(5'd0, 5'd2, 5'd4, fnSub);
        imem[5] = encodeR(5'd2, 5'd2, 5'd0, fnAdd);
        imem[6] = encodeI(opOri, 5'd0, 5'd0, 16'h1234);
        imem[7] = encodeI(opLui, 5'd0, 5'd5, 16'h8000);
        imem[8] = encodeR(5'd5, 5'd1, 5'd6, fnSub);
        imem[9] = encodeR(5'd0, 5'd0, 5'd7, fnAdd);
        runProgram("arithmetic", 10);

        clearProgram();
        imem[0] = encodeI(opLui, 5'd0, 5'd1, 16'h1234);
        imem[1] = encodeI(opOri, 5'd1, 5'd1, 16'h5678);
        imem[2] = encodeI(opOri, 5'd0, 5'd2, 16'h0100);
        imem[3] = encodeI(opSw, 5'd2, 5'd1, 16'h0000);
        imem[4] = encodeI(opLw, 5'd2, 5'd3, 16'h0000);
        imem[5] = encodeI(opLwrr, 5'd2, 5'd4, 16'h0000);
        imem[6] = encodeI(opSw, 5'd2, 5'd4, 16'h0004);
        imem[7] = encodeI(opLw, 5'd2, 5'd5, 16'h0004);
        imem[8] = encodeI(opLwrr, 5'd2, 5'd6, 16'h0004);
        imem[9] = encodeI(opLwrr, 5'd2, 5'd7, 16'hfffc);
        runProgram("loads and stores", 10);

        clearProgram();
        imem[0] = encodeI(opOri, 5'd0, 5'd1, 16'h0005);
        imem[1] = encodeI(opOri, 5'd0, 5'd2, 16'h0005);
        imem[2] = encodeI(opBeq, 5'd1, 5'd2, 16'h0001);
        imem[3] = encodeI(opOri, 5'd0, 5'd3, 16'h0001);
        imem[4] = encodeI(opBeq, 5'd1, 5'd0, 16'h0001);
        imem[5] = encodeJal(8);
        imem[6] = encodeI(opOri, 5'd0, 5'd4, 16'h0007);
        imem[7] = encodeI(opBeq, 5'd0, 5'd0, 16'hffff);
        imem[8] = encodeI(opOri, 5'd0, 5'd5, 16'h0009);
        imem[9] = encodeR(5'd31, 5'd0, 5'd0, fnJr);
        runProgram("control flow", 11);

        clearProgram();
        imem[0] = encodeI(opLui, 5'd0, 5'd1, 16'h7fff);
        imem[1] = encodeI(opOri, 5'd1, 5'd1, 16'hffff);
        imem[2] = encodeI(opOri, 5'd0, 5'd2, 16'h0001);
        imem[3] = encodeI(opBsoal, 5'd1, 5'd0, 16'h0001);
        imem[4] = encodeI(opBsoal, 5'd1, 5'd2, 16'h0001);
        imem[5] = encodeI(opOri, 5'd0, 5'd3, 16'h0001);
        imem[6] = encodeI(opLui, 5'd0, 5'd4, 16'h8000);
        imem[7] = encodeI(opBsoal, 5'd4, 5'd4, 16'h0001);
        imem[8] = encodeI(opOri, 5'd0, 5'd3, 16'h0002);
        imem[9] = encodeI(opBsoal, 5'd4, 5'd1, 16'hfff6);
        runProgram("bsoal", 9);

        clearProgram();
        buildRandomProgram();
        runProgram("random", 300);

        $display("Tests passed: %0d, failed: %0d", testsPassed, testsFailed);
        if (testsFailed == 0 && errors == 0 && UUT.checks.failures == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== singleCycleCpu.f ====
design/cpuPkg.sv
design/controlUnit.sv
design/fetchUnit.sv
design/registerFile.sv
design/executeUnit.sv
design/dataMemory.sv
design/singleCycleCpu.sv
verification/singleCycleCpu_assertions.sv
verification/singleCycleCpuTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= singleCycleCpuTb
FLAGS ?= --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   list these targets"

test:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f singleCycleCpu.f -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir
